// ==== sim/lsu_golden.txt ====
# kind op addr value tag expect (numbers in hex); load expects ld_data, commit load expects exception flag
# value is store data or speculative value; both = load sharing its cycle with the commit on the next line
load   LW  00 00000000 1 00000003
load   LW  05 00000000 2 00000008
load   LW  ff 00000000 3 00000102
load   LB  05 00000000 4 00000008
idle   LW  00 00000000 0 00000000
commit SW  10 8899aabb 0 00000000
commit SB  10 12345680 0 00000000
commit SW  21 11223344 0 00000000
commit SH  21 cafef00d 0 00000000
load   LW  10 00000000 5 8899aa80
load   LB  10 00000000 6 ffffff80
load   LBU 10 00000000 7 00000080
load   LH  10 00000000 8 ffffaa80
load   LW  21 00000000 9 1122f00d
load   LH  21 00000000 a fffff00d
load   LHU 21 00000000 b 0000f00d
both   LW  30 00000000 c 00000033
commit SW  31 55550000 0 00000000
both   LW  31 00000000 d 55550000
commit SW  32 77777777 0 00000000
load   LW  32 00000000 e 77777777
commit LW  31 55550000 0 00000000
commit LB  10 ffffff80 0 00000000
commit LW  05 00000008 0 00000000
idle   LW  00 00000000 0 00000000
idle   LW  00 00000000 0 00000000
load   LW  40 00000000 f 00000043
commit SW  40 deadbeef 0 00000000
commit LW  40 00000043 0 00000001
idle   LW  00 00000000 0 00000000

// ==== lsu_top.f ====
design/lsu_pkg.sv
design/data_memory.sv
design/mem_arbiter.sv
design/spec_load_unit.sv
design/commit_unit.sv
design/lsu_top.sv
sim/lsu_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= lsu_top_tb
FILELIST  ?= lsu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/lsu_top_tb.sv ====
module lsu_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int DEPTH  = 256;
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int KIND_IDLE   = 0;
    localparam int KIND_LOAD   = 1;
    localparam int KIND_COMMIT = 2;
    localparam int KIND_BOTH   = 3;

    logic                 clk;
    logic                 reset;
    logic                 ld_req;
    mem_op_e              ld_op;
    logic [ADDR_W-1:0]    ld_addr;
    logic [TAG_W-1:0]     ld_tag;
    logic                 ld_done;
    logic [TAG_W-1:0]     ld_done_tag;
    logic [DATA_W-1:0]    ld_data;
    logic                 cm_req;
    mem_op_e              cm_op;
    logic [ADDR_W-1:0]    cm_addr;
    logic [DATA_W-1:0]    cm_value;
    logic                 cm_check_done;
    logic                 cm_exception;

    int                rec_kind [$];  // One entry per golden record
    mem_op_e           rec_op [$];
    logic [ADDR_W-1:0] rec_addr [$];
    logic [DATA_W-1:0] rec_value [$];
    logic [TAG_W-1:0]  rec_tag [$];
    logic [DATA_W-1:0] rec_expect [$];

    logic [TAG_W-1:0]  exp_tag [$];   // Loads still waiting for ld_done
    logic [DATA_W-1:0] exp_data [$];
    bit                fast_due;      // Uncontended load must finish next cycle
    bit                check_pending;
    bit                exp_exc;
    bit                records_loaded;
    int                data_errors;
    int                other_errors;
    int                loads_checked;
    int                checks_done;

    lsu_top #(
        .DEPTH(DEPTH)
    ) lsu_top_inst (
        .clk(clk), .reset(reset),
        .ld_req(ld_req), .ld_op(ld_op), .ld_addr(ld_addr), .ld_tag(ld_tag),
        .ld_done(ld_done), .ld_done_tag(ld_done_tag), .ld_data(ld_data),
        .cm_req(cm_req), .cm_op(cm_op), .cm_addr(cm_addr), .cm_value(cm_value),
        .cm_check_done(cm_check_done), .cm_exception(cm_exception)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic parse_op(input logic [63:0] name, output mem_op_e op);
        parse_op = 1'b1;
        op = LW;
        case (name)
            "LB":    op = LB;
            "LH":    op = LH;
            "LW":    op = LW;
            "LBU":   op = LBU;
            "LHU":   op = LHU;
            "SB":    op = SB;
            "SH":    op = SH;
            "SW":    op = SW;
            default: parse_op = 1'b0;
        endcase
    endfunction

    function automatic logic is_store(input mem_op_e op);
        case (op)
            SB, SH, SW: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    task automatic load_golden();
        int            fd;
        int            code;
        int            kind_code;
        logic [63:0]   kind;
        logic [63:0]   op_name;
        logic [31:0]   addr;
        logic [31:0]   value;
        logic [31:0]   tag;
        logic [31:0]   expv;
        logic [1023:0] rest;
        mem_op_e       op;
        fd = $fopen("sim/lsu_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file sim/lsu_golden.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                kind = '0;
                code = $fscanf(fd, "%s", kind);
                if (code == 1) begin
                    if (kind == "#") begin
                        code = $fgets(rest, fd);  // Skip comment text
                    end else begin
                        code = $fscanf(fd, "%s %h %h %h %h", op_name, addr, value, tag, expv);
                        case (kind)
                            "idle":   kind_code = KIND_IDLE;
                            "load":   kind_code = KIND_LOAD;
                            "commit": kind_code = KIND_COMMIT;
                            "both":   kind_code = KIND_BOTH;
                            default:  kind_code = -1;
                        endcase
                        if (code != 5 || kind_code < 0 || !parse_op(op_name, op)) begin
                            $display("Golden file has a malformed line (kind %0s)", kind);
                            other_errors++;
                        end else begin
                            rec_kind.push_back(kind_code);
                            rec_op.push_back(op);
                            rec_addr.push_back(addr[ADDR_W-1:0]);
                            rec_value.push_back(value);
                            rec_tag.push_back(tag[TAG_W-1:0]);
                            rec_expect.push_back(expv);
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic set_idle();
        ld_req   = 1'b0;
        ld_op    = LW;
        ld_addr  = '0;
        ld_tag   = '0;
        cm_req   = 1'b0;
        cm_op    = LW;
        cm_addr  = '0;
        cm_value = '0;
    endtask

    // Outputs are all registered, so the falling edge sees settled values
    task automatic check_outputs();
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
        if (ld_done) begin
            if (exp_tag.size() == 0) begin
                $display("At %0d ns ld_done rose with no load outstanding", $time);
                other_errors++;
            end else begin
                tag  = exp_tag.pop_front();
                data = exp_data.pop_front();
                loads_checked++;
                if (ld_done_tag !== tag) begin
                    $display("[FAIL] %0d ns: ld_done_tag %0h, expected %0h", $time,
                             ld_done_tag, tag);
                    data_errors++;
                end
                if (ld_data !== data) begin
                    $display("[FAIL] %0d ns: load tag %0h returned %h, expected %h", $time,
                             tag, ld_data, data);
                    data_errors++;
                end
            end
        end
        if (fast_due && !ld_done) begin
            $display("At %0d ns an uncontended load did not finish one cycle after its request",
                     $time);
            other_errors++;
        end
        if (check_pending) begin
            checks_done++;
            if (!cm_check_done) begin
                $display("At %0d ns cm_check_done did not follow a committing load", $time);
                other_errors++;
            end else if (cm_exception !== exp_exc) begin
                $display("[FAIL] %0d ns: cm_exception %b, expected %b", $time,
                         cm_exception, exp_exc);
                data_errors++;
            end
        end else if (cm_check_done) begin
            $display("At %0d ns cm_check_done rose with no load check committed", $time);
            other_errors++;
        end
        fast_due      = 1'b0;
        check_pending = 1'b0;
    endtask

    task automatic drive_load(input int i, input bit with_commit);
        fast_due = (exp_tag.size() == 0) && !with_commit;
        ld_req   = 1'b1;
        ld_op    = rec_op[i];
        ld_addr  = rec_addr[i];
        ld_tag   = rec_tag[i];
        exp_tag.push_back(rec_tag[i]);
        exp_data.push_back(rec_expect[i]);
    endtask

    task automatic drive_commit(input int i);
        cm_req   = 1'b1;
        cm_op    = rec_op[i];
        cm_addr  = rec_addr[i];
        cm_value = rec_value[i];
        if (!is_store(rec_op[i])) begin
            check_pending = 1'b1;
            exp_exc       = rec_expect[i][0];  // Flag in bit 0
        end
    endtask

    task automatic run_records();
        int idx;
        int waited;
        idx = 0;
        while (idx < rec_kind.size()) begin
            @(negedge clk);
            check_outputs();
            set_idle();
            case (rec_kind[idx])
                KIND_LOAD: begin
                    drive_load(idx, 1'b0);
                    idx++;
                end
                KIND_COMMIT: begin
                    drive_commit(idx);
                    idx++;
                end
                KIND_BOTH: begin
                    drive_load(idx, 1'b1);  // Shares the cycle with the next commit
                    if (idx + 1 < rec_kind.size() && rec_kind[idx + 1] == KIND_COMMIT) begin
                        drive_commit(idx + 1);
                    end else begin
                        $display("Golden file has a shared-cycle load with no commit after it");
                        other_errors++;
                    end
                    idx += 2;
                end
                default: idx++;
            endcase
        end
        waited = 0;
        while ((exp_tag.size() != 0 || check_pending) && waited < 20) begin
            @(negedge clk);
            check_outputs();
            set_idle();
            waited++;
        end
        @(negedge clk);
        check_outputs();  // Catch any stray strobe
        if (exp_tag.size() != 0) begin
            $display("%0d loads never returned ld_done", exp_tag.size());
            other_errors += exp_tag.size();
        end
    endtask

    initial begin
        reset         = 1'b1;
        fast_due      = 1'b0;
        check_pending = 1'b0;
        exp_exc       = 1'b0;
        data_errors   = 0;
        other_errors  = 0;
        loads_checked = 0;
        checks_done   = 0;
        set_idle();
        load_golden();
        records_loaded = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        if (other_errors == 0) begin
            run_records();
        end
        $display("Summary: %0d loads, %0d checks, %0d value errors, %0d other errors",
                 loads_checked, checks_done, data_errors, other_errors);
        if (data_errors == 0 && other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        wait (records_loaded);
        repeat (rec_kind.size() * 10 + 100) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 rec_kind.size() * 10 + 100);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== design/lsu_top.sv ====
module lsu_top #(
    parameter int  DEPTH  = 256,
    localparam int ADDR_W = $clog2(DEPTH)
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ld_req,
    input  lsu_pkg::mem_op_e           ld_op,
    input  logic [ADDR_W-1:0]          ld_addr,
    input  logic [lsu_pkg::TAG_W-1:0]  ld_tag,
    output logic                       ld_done,
    output logic [lsu_pkg::TAG_W-1:0]  ld_done_tag,
    output logic [lsu_pkg::DATA_W-1:0] ld_data,
    input  logic                       cm_req,
    input  lsu_pkg::mem_op_e           cm_op,
    input  logic [ADDR_W-1:0]          cm_addr,
    input  logic [lsu_pkg::DATA_W-1:0] cm_value,
    output logic                       cm_check_done,
    output logic                       cm_exception
);
    import lsu_pkg::*;

    logic              ld_arb_req;  // Load unit to arbiter
    mem_op_e           ld_arb_op;
    logic [ADDR_W-1:0] ld_arb_addr;
    logic              cm_arb_req;  // Commit unit to arbiter
    logic              cm_arb_we;
    mem_op_e           cm_arb_op;
    logic [ADDR_W-1:0] cm_arb_addr;
    logic [DATA_W-1:0] cm_arb_wdata;
    logic              ld_rvalid;
    logic              cm_rvalid;
    logic              mem_en;      // Arbiter to memory
    logic              mem_we;
    mem_op_e           mem_op;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;   // Shared by both clients

    spec_load_unit #(
        .ADDR_W(ADDR_W)
    ) spec_load_unit_inst (
        .clk(clk), .reset(reset),
        .ld_req(ld_req), .ld_op(ld_op), .ld_addr(ld_addr), .ld_tag(ld_tag),
        .arb_req(ld_arb_req), .arb_op(ld_arb_op), .arb_addr(ld_arb_addr),
        .ld_rvalid(ld_rvalid), .mem_rdata(mem_rdata),
        .ld_done(ld_done), .ld_done_tag(ld_done_tag), .ld_data(ld_data)
    );

    commit_unit #(
        .ADDR_W(ADDR_W)
    ) commit_unit_inst (
        .clk(clk), .reset(reset),
        .cm_req(cm_req), .cm_op(cm_op), .cm_addr(cm_addr), .cm_value(cm_value),
        .arb_req(cm_arb_req), .arb_we(cm_arb_we), .arb_op(cm_arb_op),
        .arb_addr(cm_arb_addr), .arb_wdata(cm_arb_wdata),
        .cm_rvalid(cm_rvalid), .mem_rdata(mem_rdata),
        .cm_check_done(cm_check_done), .cm_exception(cm_exception)
    );

    mem_arbiter #(
        .ADDR_W(ADDR_W)
    ) mem_arbiter_inst (
        .clk(clk), .reset(reset),
        .ld_req(ld_arb_req), .ld_op(ld_arb_op), .ld_addr(ld_arb_addr),
        .cm_req(cm_arb_req), .cm_we(cm_arb_we), .cm_op(cm_arb_op),
        .cm_addr(cm_arb_addr), .cm_wdata(cm_arb_wdata),
        .ld_rvalid(ld_rvalid), .cm_rvalid(cm_rvalid),
        .mem_en(mem_en), .mem_we(mem_we), .mem_op(mem_op),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    data_memory #(
        .DEPTH(DEPTH),
        .ADDR_W(ADDR_W)
    ) data_memory_inst (
        .clk(clk), .reset(reset),
        .mem_en(mem_en), .mem_we(mem_we), .mem_op(mem_op),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

// ==== design/commit_unit.sv ====
module commit_unit #(
    parameter int ADDR_W = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cm_req,
    input  lsu_pkg::mem_op_e           cm_op,
    input  logic [ADDR_W-1:0]          cm_addr,
    input  logic [lsu_pkg::DATA_W-1:0] cm_value,
    output logic                       arb_req,
    output logic                       arb_we,
    output lsu_pkg::mem_op_e           arb_op,
    output logic [ADDR_W-1:0]          arb_addr,
    output logic [lsu_pkg::DATA_W-1:0] arb_wdata,
    input  logic                       cm_rvalid,
    input  logic [lsu_pkg::DATA_W-1:0] mem_rdata,
    output logic                       cm_check_done,
    output logic                       cm_exception
);
    import lsu_pkg::*;

    logic              is_store;
    logic [DATA_W-1:0] expect_q;  // Speculative value of the load under check

    always_comb begin
        case (cm_op)
            SB, SH, SW: is_store = 1'b1;
            default:    is_store = 1'b0;
        endcase
    end

    assign arb_req   = cm_req;
    assign arb_we    = is_store;
    assign arb_op    = cm_op;
    assign arb_addr  = cm_addr;
    assign arb_wdata = is_store ? cm_value : '0;  // Only stores carry data

    always_ff @(posedge clk) begin
        if (reset) begin
            expect_q <= '0;
        end else if (cm_req && !is_store) begin
            expect_q <= cm_value;
        end
    end

    // A differing re-read means a store hit the address after the speculative load
    assign cm_check_done = cm_rvalid;
    assign cm_exception  = cm_rvalid && (mem_rdata != expect_q);

endmodule

// ==== design/spec_load_unit.sv ====
module spec_load_unit #(
    parameter int ADDR_W = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ld_req,
    input  lsu_pkg::mem_op_e           ld_op,
    input  logic [ADDR_W-1:0]          ld_addr,
    input  logic [lsu_pkg::TAG_W-1:0]  ld_tag,
    output logic                       arb_req,
    output lsu_pkg::mem_op_e           arb_op,
    output logic [ADDR_W-1:0]          arb_addr,
    input  logic                       ld_rvalid,
    input  logic [lsu_pkg::DATA_W-1:0] mem_rdata,
    output logic                       ld_done,
    output logic [lsu_pkg::TAG_W-1:0]  ld_done_tag,
    output logic [lsu_pkg::DATA_W-1:0] ld_data
);
    import lsu_pkg::*;

    // One in flight plus two queued fits with room to spare
    localparam int TQ_DEPTH = 4;
    localparam int TQ_PTR_W = $clog2(TQ_DEPTH);

    logic [TAG_W-1:0]    tag_q [TQ_DEPTH];
    logic [TQ_PTR_W-1:0] tag_wr_ptr;
    logic [TQ_PTR_W-1:0] tag_rd_ptr;

    assign arb_req  = ld_req;
    assign arb_op   = ld_op;
    assign arb_addr = ld_addr;

    always_ff @(posedge clk) begin
        if (ld_req) begin
            tag_q[tag_wr_ptr] <= ld_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tag_wr_ptr <= '0;
            tag_rd_ptr <= '0;
        end else begin
            if (ld_req) begin
                tag_wr_ptr <= tag_wr_ptr + 1'b1;
            end
            if (ld_rvalid) begin
                tag_rd_ptr <= tag_rd_ptr + 1'b1;  // Oldest tag retires
            end
        end
    end

    assign ld_done     = ld_rvalid;
    assign ld_done_tag = tag_q[tag_rd_ptr];  // Reads return in issue order
    assign ld_data     = mem_rdata;

endmodule

// ==== design/mem_arbiter.sv ====
module mem_arbiter #(
    parameter int ADDR_W = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ld_req,
    input  lsu_pkg::mem_op_e           ld_op,
    input  logic [ADDR_W-1:0]          ld_addr,
    input  logic                       cm_req,
    input  logic                       cm_we,
    input  lsu_pkg::mem_op_e           cm_op,
    input  logic [ADDR_W-1:0]          cm_addr,
    input  logic [lsu_pkg::DATA_W-1:0] cm_wdata,
    output logic                       ld_rvalid,
    output logic                       cm_rvalid,
    output logic                       mem_en,
    output logic                       mem_we,
    output lsu_pkg::mem_op_e           mem_op,
    output logic [ADDR_W-1:0]          mem_addr,
    output logic [lsu_pkg::DATA_W-1:0] mem_wdata
);
    import lsu_pkg::*;

    localparam int QDEPTH = 2;
    localparam int PTR_W  = $clog2(QDEPTH);
    localparam int CNT_W  = $clog2(QDEPTH + 1);

    mem_op_e           q_op   [QDEPTH];  // Pending load operations
    logic [ADDR_W-1:0] q_addr [QDEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  q_count;
    logic              q_empty;
    logic              q_issue;
    logic              ld_bypass;
    logic              q_push;

    assign q_empty   = (q_count == '0);
    assign q_issue   = !cm_req && !q_empty;           // Head takes a free port
    assign ld_bypass = ld_req && !cm_req && q_empty;  // Straight to memory
    assign q_push    = ld_req && !ld_bypass;

    // Commit first, then the oldest queued load, then a new load
    always_comb begin
        mem_en    = cm_req || !q_empty || ld_req;
        mem_we    = cm_req && cm_we;
        mem_wdata = cm_wdata;
        if (cm_req) begin
            mem_op   = cm_op;
            mem_addr = cm_addr;
        end else if (!q_empty) begin
            mem_op   = q_op[rd_ptr];
            mem_addr = q_addr[rd_ptr];
        end else begin
            mem_op   = ld_op;
            mem_addr = ld_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) begin
            q_op[wr_ptr]   <= ld_op;
            q_addr[wr_ptr] <= ld_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            ld_rvalid <= 1'b0;
            cm_rvalid <= 1'b0;
        end else begin
            if (q_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            q_count   <= q_count + CNT_W'(q_push) - CNT_W'(q_issue);
            ld_rvalid <= !cm_req && (ld_req || !q_empty);  // Load owned the read
            cm_rvalid <= cm_req && !cm_we;                 // Check read, not a store
        end
    end

endmodule

// ==== design/data_memory.sv ====
module data_memory #(
    parameter int DEPTH  = 256,
    parameter int ADDR_W = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       mem_en,
    input  logic                       mem_we,
    input  lsu_pkg::mem_op_e           mem_op,
    input  logic [ADDR_W-1:0]          mem_addr,
    input  logic [lsu_pkg::DATA_W-1:0] mem_wdata,
    output logic [lsu_pkg::DATA_W-1:0] mem_rdata
);
    import lsu_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DATA_W-1:0] word;

    assign word = mem[mem_addr];  // Addressed word before extension

    // Sign or zero extension of the low lanes
    function automatic logic [DATA_W-1:0] extend(input mem_op_e op,
                                                 input logic [DATA_W-1:0] w);
        case (op)
            LB:      return {{(DATA_W-8){w[7]}}, w[7:0]};
            LH:      return {{(DATA_W-16){w[15]}}, w[15:0]};
            LW:      return w;
            LBU:     return {{(DATA_W-8){1'b0}}, w[7:0]};
            LHU:     return {{(DATA_W-16){1'b0}}, w[15:0]};
            default: return '0;  // Store codes never read
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= DATA_W'(i + 3);  // Word i holds i+3
            end
        end else if (mem_en && mem_we) begin
            case (mem_op)
                SB:      mem[mem_addr][7:0]  <= mem_wdata[7:0];
                SH:      mem[mem_addr][15:0] <= mem_wdata[15:0];
                SW:      mem[mem_addr]       <= mem_wdata;
                default: ;  // Load codes do not write
            endcase
        end
    end

    // Registered read, extended before it leaves the memory
    always_ff @(posedge clk) begin
        if (mem_en && !mem_we) begin
            mem_rdata <= extend(mem_op, word);
        end
    end

endmodule

// ==== design/lsu_pkg.sv ====
package lsu_pkg;

    localparam int DATA_W = 32;  // Data word width
    localparam int TAG_W  = 4;   // Reorder-buffer tag width

    // Loads keep their funct3 codes; stores sit in the spare slots
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        SB  = 3'b011,  // Byte store
        LBU = 3'b100,
        LHU = 3'b101,
        SH  = 3'b110,  // Half store
        SW  = 3'b111   // Word store
    } mem_op_e;

endpackage
